//--- gshare_pkg.sv
// gshare predictor definitions
package gshare_pkg;

    // global history width and table index width
    localparam int HIST_BITS = 10;
    localparam int PC_BITS = 32;
    localparam int TABLE_SIZE = 1 << HIST_BITS;

    // 2-bit saturating counter whose upper bit is the direction
    typedef enum logic [1:0] {
        STRONG_NT = 2'b00,
        WEAK_NT   = 2'b01,
        WEAK_T    = 2'b10,
        STRONG_T  = 2'b11
    } ctr_t;

    localparam ctr_t CTR_RESET = WEAK_NT;

    // request sitting in the lookup stage
    typedef struct packed {
        logic                 valid;
        logic [HIST_BITS-1:0] index;
        logic [HIST_BITS-1:0] hist;
    } lookup_t;

    // one outstanding prediction
    typedef struct packed {
        logic [HIST_BITS-1:0] index;
        logic [HIST_BITS-1:0] hist;
        ctr_t                 ctr;
    } pred_entry_t;

    // one counter write back into the table
    typedef struct packed {
        logic                 valid;
        logic [HIST_BITS-1:0] index;
        ctr_t                 ctr;
    } table_write_t;

endpackage : gshare_pkg

//--- lookup_stage.sv
// gshare lookup stage
`timescale 1ns/10ps

module lookup_stage (
    input  logic                             clk,
    input  logic                             rst,
    input  logic [gshare_pkg::PC_BITS-1:0]   req_pc,
    input  logic                             accept,
    input  logic                             pred_taken,
    input  logic                             recover,
    input  logic [gshare_pkg::HIST_BITS-1:0] recover_hist,
    output gshare_pkg::lookup_t              lookup,
    output logic [gshare_pkg::HIST_BITS-1:0] read_index
);
    import gshare_pkg::*;

    logic                 stage_valid_q;
    logic [HIST_BITS-1:0] stage_index_q;
    logic [HIST_BITS-1:0] stage_hist_q;
    logic [HIST_BITS-1:0] spec_hist_q;
    logic                 stage_live;
    logic [HIST_BITS-1:0] cur_hist;

    // a mispredict kills whatever sits in the stage
    assign stage_live = stage_valid_q & ~recover;

    // history seen by the next request with the in-flight direction at the low end
    assign cur_hist = stage_live ? {spec_hist_q[HIST_BITS-2:0], pred_taken}
                                 : spec_hist_q;

    assign read_index = req_pc[HIST_BITS+1:2] ^ cur_hist;

    always_ff @(posedge clk) begin
        if (rst) begin
            spec_hist_q <= '0;
            stage_valid_q <= 1'b0;
        end else if (recover) begin
            spec_hist_q <= recover_hist;
            stage_valid_q <= 1'b0;
        end else begin
            spec_hist_q <= cur_hist;
            stage_valid_q <= accept;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            stage_index_q <= read_index;
            stage_hist_q <= cur_hist;
        end
    end

    assign lookup = '{valid: stage_live, index: stage_index_q, hist: stage_hist_q};

    // requests are held off for the whole mispredict cycle
    a_no_accept_on_recover: assert property (
        @(posedge clk) disable iff (rst) !(accept && recover)
    ) else $error("request accepted during history recovery");

endmodule : lookup_stage

//--- pattern_table.sv
// gshare pattern table
`timescale 1ns/10ps

module pattern_table (
    input  logic                             clk,
    input  logic                             rst,
    input  logic [gshare_pkg::HIST_BITS-1:0] read_index,
    output gshare_pkg::ctr_t                 read_ctr,
    input  gshare_pkg::table_write_t         wr
);
    import gshare_pkg::*;

    ctr_t table_q [TABLE_SIZE];

    // every counter starts weakly not-taken
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < TABLE_SIZE; i++) begin
                table_q[i] <= CTR_RESET;
            end
        end else if (wr.valid) begin
            table_q[wr.index] <= wr.ctr;
        end
    end

    // registered read returns the old value on a same-index write
    always_ff @(posedge clk) begin
        read_ctr <= table_q[read_index];
    end

endmodule : pattern_table

//--- prediction_queue.sv
// outstanding prediction FIFO
`timescale 1ns/10ps

module prediction_queue #(
    parameter int QUEUE_DEPTH = 4
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    flush,
    input  logic                    push,
    input  gshare_pkg::pred_entry_t push_entry,
    input  logic                    in_flight,
    input  logic                    pop,
    output gshare_pkg::pred_entry_t head,
    output logic                    has_entry,
    output logic                    room
);
    import gshare_pkg::*;

    localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
    localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);
    localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(QUEUE_DEPTH - 1);
    localparam logic [CNT_W-1:0] DEPTH_CNT = CNT_W'(QUEUE_DEPTH);

    pred_entry_t      mem_q [QUEUE_DEPTH];
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] count_q;
    logic [CNT_W:0]   occupancy;
    logic             live_q;
    logic             full;

    // the lookup stage item will land here, so it counts as taken
    assign occupancy = {1'b0, count_q} + {{CNT_W{1'b0}}, in_flight};
    assign full = (count_q == DEPTH_CNT);
    assign has_entry = (count_q != '0);
    assign room = live_q & (occupancy < {1'b0, DEPTH_CNT});
    assign head = mem_q[rd_ptr_q];

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q <= '0;
            live_q <= 1'b0;
        end else if (flush) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q <= '0;
            live_q <= 1'b1;
        end else begin
            live_q <= 1'b1;
            if (push) begin
                wr_ptr_q <= (wr_ptr_q == LAST_PTR) ? '0 : wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= (rd_ptr_q == LAST_PTR) ? '0 : rd_ptr_q + 1'b1;
            end
            case ({push, pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push && !flush) begin
            mem_q[wr_ptr_q] <= push_entry;
        end
    end

    // request back-pressure must keep these from ever firing
    a_no_push_full: assert property (
        @(posedge clk) disable iff (rst) !(push && !flush && full)
    ) else $error("push into full prediction queue");

    a_no_pop_empty: assert property (
        @(posedge clk) disable iff (rst) !(pop && !has_entry)
    ) else $error("pop from empty prediction queue");

endmodule : prediction_queue

//--- branch_resolver.sv
// branch resolution and counter update
`timescale 1ns/10ps

module branch_resolver (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             res_fire,
    input  logic                             res_taken,
    input  gshare_pkg::pred_entry_t          head,
    output gshare_pkg::table_write_t         wr,
    output logic                             mispredict,
    output logic [gshare_pkg::HIST_BITS-1:0] recover_hist
);
    import gshare_pkg::*;

    ctr_t                 next_ctr;
    logic                 predicted;
    logic                 wr_valid_q;
    logic [HIST_BITS-1:0] wr_index_q;
    ctr_t                 wr_ctr_q;

    assign predicted = (head.ctr == WEAK_T) || (head.ctr == STRONG_T);

    // saturating step from the counter stored at prediction time
    always_comb begin
        case (head.ctr)
            STRONG_NT: next_ctr = res_taken ? WEAK_NT : STRONG_NT;
            WEAK_NT:   next_ctr = res_taken ? WEAK_T : STRONG_NT;
            WEAK_T:    next_ctr = res_taken ? STRONG_T : WEAK_NT;
            STRONG_T:  next_ctr = res_taken ? STRONG_T : WEAK_T;
            default:   next_ctr = CTR_RESET;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_valid_q <= 1'b0;
            mispredict <= 1'b0;
        end else begin
            wr_valid_q <= res_fire;
            mispredict <= res_fire & (res_taken != predicted);
        end
    end

    always_ff @(posedge clk) begin
        if (res_fire) begin
            wr_index_q <= head.index;
            wr_ctr_q <= next_ctr;
            // history right after this branch, with its real outcome
            recover_hist <= {head.hist[HIST_BITS-2:0], res_taken};
        end
    end

    assign wr = '{valid: wr_valid_q, index: wr_index_q, ctr: wr_ctr_q};

    // flush empties the queue, so no resolve can follow at once
    a_single_mispredict: assert property (
        @(posedge clk) disable iff (rst) mispredict |=> !mispredict
    ) else $error("mispredict held for two cycles");

endmodule : branch_resolver

//--- gshare_predictor.sv
// gshare branch direction predictor
`timescale 1ns/10ps

module gshare_predictor #(
    parameter int QUEUE_DEPTH = 4
) (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           req_valid,
    input  logic [gshare_pkg::PC_BITS-1:0] req_pc,
    output logic                           req_ready,
    output logic                           pred_valid,
    output logic                           pred_taken,
    input  logic                           res_valid,
    input  logic                           res_taken,
    output logic                           res_ready,
    output logic                           mispredict
);
    import gshare_pkg::*;

    lookup_t              lookup;
    logic [HIST_BITS-1:0] read_index;
    ctr_t                 read_ctr;
    table_write_t         wr;
    pred_entry_t          push_entry;
    pred_entry_t          head;
    logic [HIST_BITS-1:0] recover_hist;
    logic                 accept;
    logic                 res_fire;
    logic                 has_entry;
    logic                 room;

    assign accept = req_valid & req_ready;
    assign res_fire = res_valid & res_ready;
    assign req_ready = room & ~mispredict;
    assign res_ready = has_entry & ~mispredict;

    assign pred_valid = lookup.valid;
    assign pred_taken = read_ctr[1];

    assign push_entry = '{index: lookup.index, hist: lookup.hist, ctr: read_ctr};

    lookup_stage u_lookup (
        .clk,
        .rst,
        .req_pc,
        .accept,
        .pred_taken,
        .recover(mispredict),
        .recover_hist,
        .lookup,
        .read_index
    );

    pattern_table u_table (
        .clk,
        .rst,
        .read_index,
        .read_ctr,
        .wr
    );

    prediction_queue #(
        .QUEUE_DEPTH(QUEUE_DEPTH)
    ) u_queue (
        .clk,
        .rst,
        .flush(mispredict),
        .push(pred_valid),
        .push_entry,
        .in_flight(lookup.valid),
        .pop(res_fire),
        .head,
        .has_entry,
        .room
    );

    branch_resolver u_resolver (
        .clk,
        .rst,
        .res_fire,
        .res_taken,
        .head,
        .wr,
        .mispredict,
        .recover_hist
    );

endmodule : gshare_predictor

//--- tb_gshare_predictor.sv
// gshare predictor testbench
`timescale 1ns/10ps

module tb_gshare_predictor;
    import gshare_pkg::*;

    localparam int DEPTH = 4;
    localparam int STIM_CYCLES = 1500;
    // twice the stimulus length
    localparam int TIMEOUT_CYCLES = 2 * STIM_CYCLES;

    typedef struct packed {
        logic [HIST_BITS-1:0] index;
        logic [HIST_BITS-1:0] hist;
        logic [1:0]           ctr;
        logic [2:0]           pc_sel;
    } model_entry_t;

    logic               clk;
    logic               rst;
    logic               req_valid = 1'b0;
    logic [PC_BITS-1:0] req_pc = '0;
    logic [2:0]         req_sel = '0;
    logic               req_ready;
    logic               pred_valid;
    logic               pred_taken;
    logic               res_valid = 1'b0;
    logic               res_taken = 1'b0;
    logic               res_ready;
    logic               mispredict;

    // reference model
    logic [1:0]           model_ctr [TABLE_SIZE];
    logic [HIST_BITS-1:0] model_hist;
    logic                 stage_valid;
    model_entry_t         stage_entry;
    model_entry_t         pending_q [$];
    logic                 exp_mispredict;
    logic [HIST_BITS-1:0] exp_recover_hist;
    logic                 wb_valid;
    logic [HIST_BITS-1:0] wb_index;
    logic [1:0]           wb_ctr;

    logic [15:0] lfsr_state = 16'd40;
    logic        stim_done = 1'b0;
    int          run_cycles = 0;
    int          cycle_count = 0;
    int          accept_count = 0;
    int          mispredict_count = 0;
    int          stall_count = 0;
    int          taken_count = 0;

    gshare_predictor #(
        .QUEUE_DEPTH(DEPTH)
    ) UUT (
        .clk,
        .rst,
        .req_valid,
        .req_pc,
        .req_ready,
        .pred_valid,
        .pred_taken,
        .res_valid,
        .res_taken,
        .res_ready,
        .mispredict
    );

    function automatic logic [15:0] lfsr_next(input logic [15:0] state);
        // x^16 + x^14 + x^13 + x^11 + 1
        return state[0] ? ((state >> 1) ^ 16'hB400) : (state >> 1);
    endfunction

    task automatic draw_bits(input int count, output logic [7:0] value);
        value = '0;
        for (int i = 0; i < count; i++) begin
            value = {value[6:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    // eight branch addresses so that indices repeat
    function automatic logic [PC_BITS-1:0] pool_pc(input logic [2:0] sel);
        return 32'h0000_4000 + {27'd0, sel, 2'b00} * 32'd9;
    endfunction

    task automatic fail_stop();
        $display("Verification failed");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic value_error(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        $display("ERROR: %s is 0x%0h, expected 0x%0h (cycle %0d)", name, got, exp, cycle_count);
        fail_stop();
    endtask

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        wait (stim_done);
        @(negedge clk);
        if (accept_count > 0 && mispredict_count > 0 && stall_count > 0 && taken_count > 0) begin
            $display("Verification passed");
            $finish;
        end else begin
            $display("stimulus missed a behavior: %0d accepts, %0d mispredicts, %0d stalls",
                     accept_count, mispredict_count, stall_count);
            $display("stimulus reached %0d taken predictions", taken_count);
            $display("Verification failed");
            $fatal(1, "coverage incomplete");
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            fail_stop();
        end
    end

    // model step, checks and next inputs from pre-edge values
    always @(posedge clk) begin
        logic                 exp_pred;
        logic                 exp_req_ready;
        logic                 exp_res_ready;
        logic                 accept;
        logic                 res_fire;
        logic                 withhold;
        logic [HIST_BITS-1:0] cur_hist;
        logic [HIST_BITS-1:0] index;
        logic [1:0]           next_ctr;
        logic [2:0]           head_sel;
        logic [7:0]           bits;
        int                   occupancy;
        model_entry_t         head;

        if (rst) begin
            for (int i = 0; i < TABLE_SIZE; i++) begin
                model_ctr[i] = 2'b01;
            end
            model_hist = '0;
            stage_valid = 1'b0;
            pending_q.delete();
            exp_mispredict = 1'b0;
            exp_recover_hist = '0;
            wb_valid = 1'b0;
            req_valid <= 1'b0;
            res_valid <= 1'b0;
        end else begin
            exp_pred = stage_valid && !exp_mispredict;
            occupancy = pending_q.size() + (exp_pred ? 1 : 0);
            exp_req_ready = !exp_mispredict && occupancy < DEPTH;
            exp_res_ready = pending_q.size() > 0 && !exp_mispredict;

            assert (mispredict == exp_mispredict)
                else value_error("mispredict", 32'(mispredict), 32'(exp_mispredict));
            assert (pred_valid == exp_pred)
                else value_error("pred_valid", 32'(pred_valid), 32'(exp_pred));
            if (exp_pred) begin
                assert (pred_taken == stage_entry.ctr[1])
                    else value_error("pred_taken", 32'(pred_taken), 32'(stage_entry.ctr[1]));
            end
            assert (res_ready == exp_res_ready)
                else value_error("res_ready", 32'(res_ready), 32'(exp_res_ready));
            // queue comes out of reset closed for one cycle
            assert (req_ready == exp_req_ready || (run_cycles == 0 && !req_ready))
                else value_error("req_ready", 32'(req_ready), 32'(exp_req_ready));

            accept = req_valid && req_ready;
            res_fire = res_valid && res_ready;
            cur_hist = exp_pred ? {model_hist[HIST_BITS-2:0], stage_entry.ctr[1]} : model_hist;
            index = req_pc[HIST_BITS+1:2] ^ cur_hist;

            if (accept) accept_count++;
            if (exp_mispredict) mispredict_count++;
            if (occupancy >= DEPTH) stall_count++;
            if (exp_pred && pred_taken) taken_count++;

            if (res_fire) begin
                head = pending_q.pop_front();
                if (res_taken) begin
                    next_ctr = (head.ctr == 2'b11) ? 2'b11 : head.ctr + 2'b01;
                end else begin
                    next_ctr = (head.ctr == 2'b00) ? 2'b00 : head.ctr - 2'b01;
                end
            end

            if (exp_mispredict) begin
                model_hist = exp_recover_hist;
                stage_valid = 1'b0;
                pending_q.delete();
            end else begin
                if (exp_pred) pending_q.push_back(stage_entry);
                model_hist = cur_hist;
                stage_valid = accept;
                if (accept) begin
                    // read happens before this edge's counter write
                    stage_entry = '{index: index, hist: cur_hist, ctr: model_ctr[index],
                                    pc_sel: req_sel};
                end
            end

            if (wb_valid) model_ctr[wb_index] = wb_ctr;
            wb_valid = res_fire;
            exp_mispredict = 1'b0;
            if (res_fire) begin
                wb_index = head.index;
                wb_ctr = next_ctr;
                exp_mispredict = res_taken != head.ctr[1];
                exp_recover_hist = {head.hist[HIST_BITS-2:0], res_taken};
            end

            // next inputs
            if (run_cycles < STIM_CYCLES) begin
                withhold = ((run_cycles / 200) % 2) == 0;
                draw_bits(2, bits);
                req_valid <= bits[1:0] != 2'b00;
                draw_bits(3, bits);
                req_sel <= bits[2:0];
                req_pc <= pool_pc(bits[2:0]);
                draw_bits(3, bits);
                res_valid <= withhold ? (bits[2:0] == 3'b000) : bits[0];
                // outcome biased per branch so counters train and saturate
                head_sel = (pending_q.size() > 0) ? pending_q[0].pc_sel : 3'd0;
                draw_bits(1, bits);
                if (head_sel < 3'd4) begin
                    res_taken <= 1'b1;
                end else if (head_sel < 3'd6) begin
                    res_taken <= 1'b0;
                end else begin
                    res_taken <= bits[0];
                end
            end else begin
                req_valid <= 1'b0;
                res_valid <= 1'b0;
                stim_done <= 1'b1;
            end
            run_cycles++;
        end
    end

    a_pred_follows_accept: assert property (
        @(posedge clk) disable iff (rst) (req_valid && req_ready) |=> (pred_valid || mispredict)
    ) else begin
        $display("accepted request got no prediction on the next cycle");
        fail_stop();
    end

    a_flush_blocks_resolve: assert property (
        @(posedge clk) disable iff (rst) mispredict |=> !res_ready
    ) else begin
        $display("resolve was still possible right after a mispredict flush");
        fail_stop();
    end

endmodule : tb_gshare_predictor

//--- gshare_predictor.f
gshare_pkg.sv
lookup_stage.sv
pattern_table.sv
prediction_queue.sv
branch_resolver.sv
gshare_predictor.sv
tb_gshare_predictor.sv

//--- Makefile
# Verilator build and run for the gshare predictor

VERILATOR ?= verilator
TOP       ?= tb_gshare_predictor
FILELIST  ?= gshare_predictor.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_TEXT ?= Verification passed

SIM_BIN := $(BUILD_DIR)/V$(TOP)
SOURCES := $(wildcard *.sv)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS PASS_TEXT"

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(SIM_BIN)
	@out="$$(./$(SIM_BIN) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)
